// File: game_view.sv
// game view top level
// background and object frame pipeline with round state tracking
`timescale 1ns/1ps

module game_view import view_pkg::*; (
	input  logic        clk,
	input  logic        resetn,
	input  logic        go,
	input  logic        map_load,
	input  obj_index_t  map_index,
	input  obj_rec_t    map_data,
	input  logic        collect,
	input  obj_index_t  collect_index,
	output pixel_t      pixel,
	output logic        write_en,
	output view_state_t state,
	output level_t      level,
	output score_t      score,
	output time_t       time_left
);

	logic       scan_start;
	logic       scan_background;
	logic       scan_done;
	logic       scan_valid;
	scan_pos_t  scan_pos;
	obj_index_t obj_sel;
	obj_rec_t   obj;
	logic       frame_tick;
	logic       round_start;
	logic       level_up;
	logic       goal_met;
	logic       time_up;
	logic       collect_hit;
	obj_kind_t  collect_kind;

	// map loads only between games
	wire map_load_ok = map_load && (state == IDLE || state == GAME_OVER || state == GAME_WIN);

	round_sequencer u_sequencer (
		.clk             (clk),
		.resetn          (resetn),
		.go              (go),
		.scan_done       (scan_done),
		.goal_met        (goal_met),
		.time_up         (time_up),
		.level           (level),
		.state           (state),
		.scan_start      (scan_start),
		.scan_background (scan_background),
		.obj_sel         (obj_sel),
		.frame_tick      (frame_tick),
		.round_start     (round_start),
		.level_up        (level_up)
	);

	object_map u_map (
		.clk           (clk),
		.resetn        (resetn),
		.map_load      (map_load_ok),
		.map_index     (map_index),
		.map_data      (map_data),
		.collect       (collect),
		.collect_index (collect_index),
		.round_start   (round_start),
		.level_up      (level_up),
		.obj_sel       (obj_sel),
		.obj           (obj),
		.collect_hit   (collect_hit),
		.collect_kind  (collect_kind)
	);

	sprite_scanner u_scanner (
		.clk             (clk),
		.resetn          (resetn),
		.scan_start      (scan_start),
		.scan_background (scan_background),
		.obj             (obj),
		.scan_pos        (scan_pos),
		.scan_valid      (scan_valid),
		.scan_done       (scan_done)
	);

	pixel_writer u_writer (
		.clk        (clk),
		.resetn     (resetn),
		.scan_pos   (scan_pos),
		.scan_valid (scan_valid),
		.pixel      (pixel),
		.write_en   (write_en)
	);

	round_keeper u_keeper (
		.clk          (clk),
		.resetn       (resetn),
		.collect_hit  (collect_hit),
		.collect_kind (collect_kind),
		.frame_tick   (frame_tick),
		.round_start  (round_start),
		.level_up     (level_up),
		.score        (score),
		.level        (level),
		.time_left    (time_left),
		.goal_met     (goal_met),
		.time_up      (time_up)
	);

endmodule

// File: game_view_assert.sv
// write checks bound to the game view top level
// quiet write strobe after reset, no transparent writes, nothing off screen
`timescale 1ns/1ps
`include "view_defs.svh"

module game_view_assert import view_pkg::*; (
	input logic   clk,
	input logic   resetn,
	input logic   write_en,
	input pixel_t pixel
);

	// count of failed assertions
	int fail_count = 0;

	// reset clears the strobe by the next edge
	property quiet_after_reset;
		@(posedge clk) !resetn |=> !write_en;
	endproperty

	property no_clear_write;
		@(posedge clk) disable iff (!resetn) write_en |-> pixel.color != `COLOR_CLEAR;
	endproperty

	property on_screen;
		@(posedge clk) disable iff (!resetn)
			write_en |-> (pixel.x < `SCREEN_W && pixel.y < `SCREEN_H);
	endproperty

	assert property (quiet_after_reset) else begin
		$error("write_en high right after reset");
		fail_count++;
	end
	assert property (no_clear_write) else begin
		$error("write with transparent colour");
		fail_count++;
	end
	assert property (on_screen) else begin
		$error("write address off screen");
		fail_count++;
	end

endmodule

bind game_view game_view_assert u_assert (
	.clk      (clk),
	.resetn   (resetn),
	.write_en (write_en),
	.pixel    (pixel)
);

// File: list.f
+incdir+.
view_pkg.sv
object_map.sv
round_sequencer.sv
sprite_scanner.sv
pixel_writer.sv
round_keeper.sv
game_view.sv
game_view_assert.sv
tb_game_view.sv

// File: object_map.sv
// object map
// fifteen object records with load and collect ports, visibility restored per round
`timescale 1ns/1ps
`include "view_defs.svh"

module object_map import view_pkg::*; (
	input  logic       clk,
	input  logic       resetn,
	input  logic       map_load,
	input  obj_index_t map_index,
	input  obj_rec_t   map_data,
	input  logic       collect,
	input  obj_index_t collect_index,
	input  logic       round_start,
	input  logic       level_up,
	input  obj_index_t obj_sel,
	output obj_rec_t   obj,
	output logic       collect_hit,
	output obj_kind_t  collect_kind
);

	obj_rec_t             rec_q [`OBJ_COUNT];
	logic [`OBJ_COUNT-1:0] visible_q;
	logic [`OBJ_COUNT-1:0] loaded_q;
	logic                 sel_ok;
	logic                 collect_ok;

	assign sel_ok     = obj_sel < obj_index_t'(`OBJ_COUNT);
	assign collect_ok = collect_index < obj_index_t'(`OBJ_COUNT);

	// combinational read for the scanner
	always_comb begin
		obj = '0;
		if (sel_ok) begin
			obj         = rec_q[obj_sel];
			obj.visible = visible_q[obj_sel];
		end
	end

	// only a visible object scores
	assign collect_hit  = collect && collect_ok && visible_q[collect_index];
	assign collect_kind = collect_ok ? rec_q[collect_index].kind : KIND_GOLD;

	always_ff @(posedge clk) begin
		if (map_load && map_index < obj_index_t'(`OBJ_COUNT)) begin
			rec_q[map_index] <= map_data;
		end
	end

	always_ff @(posedge clk) begin
		if (!resetn) begin
			visible_q <= '0;
			loaded_q  <= '0;
		end else begin
			if (round_start || level_up) begin
				visible_q <= loaded_q;
			end else if (collect_hit) begin
				visible_q[collect_index] <= 1'b0;
			end
			if (map_load && map_index < obj_index_t'(`OBJ_COUNT)) begin
				loaded_q[map_index]  <= 1'b1;
				visible_q[map_index] <= map_data.visible;
			end
		end
	end

endmodule

// File: pixel_writer.sv
// pixel writer, the result stage
// colours each scan position, drops transparent corners and registers the write
`timescale 1ns/1ps
`include "view_defs.svh"

module pixel_writer import view_pkg::*; (
	input  logic      clk,
	input  logic      resetn,
	input  scan_pos_t scan_pos,
	input  logic      scan_valid,
	output pixel_t    pixel,
	output logic      write_en
);

	pixel_t pixel_d;
	color_t palette;
	logic   corner_x;
	logic   corner_y;
	logic   in_corner;

	always_comb begin
		case (scan_pos.kind)
			KIND_GOLD:    palette = `COLOR_GOLD;
			KIND_STONE:   palette = `COLOR_STONE;
			KIND_DIAMOND: palette = `COLOR_DIAMOND;
			default:      palette = `COLOR_CLEAR;
		endcase
	end

	// 2x2 cut at each sprite corner
	assign corner_x  = scan_pos.dx < `CORNER_SIZE ||
	                   scan_pos.dx >= `SPRITE_SIZE - `CORNER_SIZE;
	assign corner_y  = scan_pos.dy < `CORNER_SIZE ||
	                   scan_pos.dy >= `SPRITE_SIZE - `CORNER_SIZE;
	assign in_corner = !scan_pos.background && corner_x && corner_y;

	always_comb begin
		pixel_d.x = scan_pos.base_x + scan_pos.dx;
		pixel_d.y = scan_pos.base_y + scan_pos.dy;
		if (in_corner) begin
			pixel_d.color = `COLOR_CLEAR;
		end else if (scan_pos.background) begin
			pixel_d.color = `COLOR_BG;
		end else begin
			pixel_d.color = palette;
		end
	end

	always_ff @(posedge clk) begin
		pixel <= pixel_d;
	end

	always_ff @(posedge clk) begin
		if (!resetn) begin
			write_en <= 1'b0;
		end else begin
			write_en <= scan_valid && scan_pos.visible && pixel_d.color != `COLOR_CLEAR;
		end
	end

endmodule

// File: round_keeper.sv
// round keeper
// score accumulation against the level goal, level register and round timer
`timescale 1ns/1ps
`include "view_defs.svh"

module round_keeper import view_pkg::*; (
	input  logic      clk,
	input  logic      resetn,
	input  logic      collect_hit,
	input  obj_kind_t collect_kind,
	input  logic      frame_tick,
	input  logic      round_start,
	input  logic      level_up,
	output score_t    score,
	output level_t    level,
	output time_t     time_left,
	output logic      goal_met,
	output logic      time_up
);

	score_t      value;
	score_t      goal;
	logic [10:0] sum;

	always_comb begin
		case (collect_kind)
			KIND_GOLD:    value = score_t'(`VALUE_GOLD);
			KIND_STONE:   value = score_t'(`VALUE_STONE);
			KIND_DIAMOND: value = score_t'(`VALUE_DIAMOND);
			default:      value = '0;
		endcase
	end

	// goal grows by one step per level
	assign goal     = score_t'(`GOAL_BASE) + score_t'(`GOAL_STEP) * score_t'(level);
	assign goal_met = score >= goal;
	assign time_up  = time_left == '0;

	assign sum = {1'b0, score} + {1'b0, value};

	always_ff @(posedge clk) begin
		if (!resetn) begin
			score     <= '0;
			level     <= '0;
			time_left <= time_t'(`ROUND_TIME);
		end else if (round_start || level_up) begin
			score     <= '0;
			time_left <= time_t'(`ROUND_TIME);
			if (round_start) begin
				level <= '0;
			end else begin
				level <= level + 3'd1;
			end
		end else begin
			if (collect_hit) begin
				// saturate at the top of the score range
				score <= sum[10] ? '1 : sum[9:0];
			end
			if (frame_tick && !time_up) begin
				time_left <= time_left - 4'd1;
			end
		end
	end

endmodule

// File: round_sequencer.sv
// round sequencer, the decode stage
// orders the background pass, the object frames and the round-end decisions
`timescale 1ns/1ps
`include "view_defs.svh"

module round_sequencer import view_pkg::*; (
	input  logic        clk,
	input  logic        resetn,
	input  logic        go,
	input  logic        scan_done,
	input  logic        goal_met,
	input  logic        time_up,
	input  level_t      level,
	output view_state_t state,
	output logic        scan_start,
	output logic        scan_background,
	output obj_index_t  obj_sel,
	output logic        frame_tick,
	output logic        round_start,
	output logic        level_up
);

	view_state_t state_d;
	obj_index_t  sel_d;
	logic        busy_q;
	logic        busy_d;
	logic        last_obj;
	logic        win_level;

	assign last_obj        = obj_sel == obj_index_t'(`OBJ_COUNT - 1);
	assign win_level       = level == level_t'(`LAST_LEVEL - 1);
	assign scan_background = state == CLEAR;

	always_comb begin
		state_d     = state;
		sel_d       = obj_sel;
		busy_d      = busy_q;
		scan_start  = 1'b0;
		frame_tick  = 1'b0;
		round_start = 1'b0;
		level_up    = 1'b0;
		case (state)
			IDLE, GAME_OVER, GAME_WIN: begin
				if (go) begin
					round_start = 1'b1;
					busy_d      = 1'b0;
					sel_d       = '0;
					state_d     = CLEAR;
				end
			end
			CLEAR, OBJECTS: begin
				// busy marks a scan in flight
				if (!busy_q) begin
					scan_start = 1'b1;
					busy_d     = 1'b1;
				end else if (scan_done) begin
					busy_d = 1'b0;
					if (state == CLEAR) begin
						state_d = OBJECTS;
						sel_d   = '0;
					end else if (last_obj) begin
						state_d = FRAME_END;
						sel_d   = '0;
					end else begin
						sel_d = obj_sel + 4'd1;
					end
				end
			end
			FRAME_END: begin
				// tick first, decide once the timer has moved
				if (!busy_q) begin
					frame_tick = 1'b1;
					busy_d     = 1'b1;
				end else begin
					busy_d = 1'b0;
					if (goal_met && win_level) begin
						state_d = GAME_WIN;
					end else if (goal_met) begin
						state_d = LEVEL_UP;
					end else if (time_up) begin
						state_d = GAME_OVER;
					end else begin
						state_d = OBJECTS;
					end
				end
			end
			LEVEL_UP: begin
				level_up = 1'b1;
				state_d  = CLEAR;
			end
			default: begin
				state_d = IDLE;
			end
		endcase
	end

	always_ff @(posedge clk) begin
		if (!resetn) begin
			state   <= IDLE;
			obj_sel <= '0;
			busy_q  <= 1'b0;
		end else begin
			state   <= state_d;
			obj_sel <= sel_d;
			busy_q  <= busy_d;
		end
	end

endmodule

// File: sprite_scanner.sv
// sprite scanner, the execute stage
// walks the full screen or one 20x20 sprite, one position per cycle
`timescale 1ns/1ps
`include "view_defs.svh"

module sprite_scanner import view_pkg::*; (
	input  logic      clk,
	input  logic      resetn,
	input  logic      scan_start,
	input  logic      scan_background,
	input  obj_rec_t  obj,
	output scan_pos_t scan_pos,
	output logic      scan_valid,
	output logic      scan_done
);

	coord_x_t last_x;
	coord_y_t last_y;
	logic     at_last;

	assign last_x = scan_pos.background ? coord_x_t'(`SCREEN_W - 1) :
	                                      coord_x_t'(`SPRITE_SIZE - 1);
	assign last_y = scan_pos.background ? coord_y_t'(`SCREEN_H - 1) :
	                                      coord_y_t'(`SPRITE_SIZE - 1);

	assign at_last   = scan_pos.dx == last_x && scan_pos.dy == last_y;
	assign scan_done = scan_valid && at_last;

	always_ff @(posedge clk) begin
		if (!resetn) begin
			scan_valid <= 1'b0;
		end else if (scan_start) begin
			scan_valid <= 1'b1;
		end else if (scan_done) begin
			scan_valid <= 1'b0;
		end
	end

	// position registers
	always_ff @(posedge clk) begin
		if (scan_start) begin
			scan_pos.dx         <= '0;
			scan_pos.dy         <= '0;
			scan_pos.kind       <= obj.kind;
			scan_pos.background <= scan_background;
			if (scan_background) begin
				// full screen from the origin
				scan_pos.base_x  <= '0;
				scan_pos.base_y  <= '0;
				scan_pos.visible <= 1'b1;
			end else begin
				scan_pos.base_x  <= obj.x;
				scan_pos.base_y  <= obj.y;
				scan_pos.visible <= obj.visible;
			end
		end else if (scan_valid && !at_last) begin
			if (scan_pos.dx == last_x) begin
				scan_pos.dx <= '0;
				scan_pos.dy <= scan_pos.dy + 8'd1;
			end else begin
				scan_pos.dx <= scan_pos.dx + 9'd1;
			end
		end
	end

endmodule

// File: tb_game_view.sv
// testbench for the game view controller
// checks background and sprite writes, collects, level up, timeout and win
`timescale 1ns/1ps
`include "view_defs.svh"

module tb_game_view import view_pkg::*; ();

	localparam int WAIT_LIMIT    = 100000;
	localparam int QUIET_CYCLES  = 500;
	localparam int SPRITE_WRITES = `SPRITE_SIZE * `SPRITE_SIZE - 4 * `CORNER_SIZE * `CORNER_SIZE;
	localparam int SCORE_MAX     = (1 << $bits(score_t)) - 1;

	logic        clk;
	logic        resetn;
	logic        go;
	logic        map_load;
	obj_index_t  map_index;
	obj_rec_t    map_data;
	logic        collect;
	obj_index_t  collect_index;
	pixel_t      pixel;
	logic        write_en;
	view_state_t state;
	level_t      level;
	score_t      score;
	time_t       time_left;

	// reference model of the object table and score
	int        obj_x [`OBJ_COUNT];
	int        obj_y [`OBJ_COUNT];
	obj_kind_t obj_kind [`OBJ_COUNT];
	bit        obj_vis [`OBJ_COUNT];
	int        model_score;
	int        coll_idx [$];
	int        coll_score [$];

	// write statistics gathered by the monitor
	longint bg_count;
	longint bg_sum_x;
	longint bg_sum_y;
	int     obj_hits [`OBJ_COUNT];
	int     obj_total;
	int     write_total;

	game_view DUT (
		.clk           (clk),
		.resetn        (resetn),
		.go            (go),
		.map_load      (map_load),
		.map_index     (map_index),
		.map_data      (map_data),
		.collect       (collect),
		.collect_index (collect_index),
		.pixel         (pixel),
		.write_en      (write_en),
		.state         (state),
		.level         (level),
		.score         (score),
		.time_left     (time_left)
	);

	initial begin
		clk = 1'b0;
		forever #4 clk = ~clk;
	end

	task automatic abort_run(input string why);
		$display("%s", why);
		$display("Some tests failed");
		$fatal(1);
	endtask

	task automatic check(input longint actual, input longint expected, input string what);
		if (actual != expected) begin
			$display("FAIL %0t ns: %s: got %0d, expected %0d", $time, what, actual, expected);
			$display("Some tests failed");
			$fatal(1);
		end
	endtask

	function automatic color_t kind_color(input obj_kind_t kind);
		case (kind)
			KIND_GOLD:    return `COLOR_GOLD;
			KIND_STONE:   return `COLOR_STONE;
			KIND_DIAMOND: return `COLOR_DIAMOND;
			default:      return `COLOR_CLEAR;
		endcase
	endfunction

	function automatic int kind_value(input obj_kind_t kind);
		case (kind)
			KIND_GOLD:    return `VALUE_GOLD;
			KIND_STONE:   return `VALUE_STONE;
			KIND_DIAMOND: return `VALUE_DIAMOND;
			default:      return 0;
		endcase
	endfunction

	function automatic int score_after(input int idx);
		int s;
		s = model_score;
		if (obj_vis[idx]) begin
			s = s + kind_value(obj_kind[idx]);
		end
		return (s > SCORE_MAX) ? SCORE_MAX : s;
	endfunction

	// sort every write into background or the sprite it lands in
	always @(posedge clk) begin : watch_writes
		int j;
		int hit;
		int dx;
		int dy;
		if (resetn && write_en) begin
			write_total = write_total + 1;
			if (pixel.color == `COLOR_BG) begin
				bg_count = bg_count + 1;
				bg_sum_x = bg_sum_x + pixel.x;
				bg_sum_y = bg_sum_y + pixel.y;
			end else begin
				hit = -1;
				for (j = 0; j < `OBJ_COUNT; j++) begin
					dx = int'(pixel.x) - obj_x[j];
					dy = int'(pixel.y) - obj_y[j];
					if (dx >= 0 && dx < `SPRITE_SIZE && dy >= 0 && dy < `SPRITE_SIZE) begin
						hit = j;
					end
				end
				if (hit < 0) begin
					abort_run($sformatf("sprite write at %0d,%0d outside every object",
						pixel.x, pixel.y));
				end
				dx = int'(pixel.x) - obj_x[hit];
				dy = int'(pixel.y) - obj_y[hit];
				if ((dx < `CORNER_SIZE || dx >= `SPRITE_SIZE - `CORNER_SIZE) &&
				    (dy < `CORNER_SIZE || dy >= `SPRITE_SIZE - `CORNER_SIZE)) begin
					abort_run($sformatf("write in a transparent corner of object %0d", hit));
				end
				check(pixel.color, kind_color(obj_kind[hit]), "sprite colour");
				obj_hits[hit] = obj_hits[hit] + 1;
				obj_total     = obj_total + 1;
			end
		end
	end

	// the bound checker counts its failed assertions
	always @(posedge clk) begin
		check(DUT.u_assert.fail_count, 0, "failed write assertions");
	end

	task automatic clear_counts;
		int j;
		bg_count  = 0;
		bg_sum_x  = 0;
		bg_sum_y  = 0;
		obj_total = 0;
		for (j = 0; j < `OBJ_COUNT; j++) begin
			obj_hits[j] = 0;
		end
	endtask

	// lets the monitor count the last write in flight
	task automatic settle;
		@(posedge clk);
		@(negedge clk);
	endtask

	task automatic await_state(input view_state_t target, input bit leave);
		int cycles;
		cycles = 0;
		while ((state == target) == leave) begin
			@(negedge clk);
			cycles++;
			if (cycles > WAIT_LIMIT) begin
				abort_run($sformatf("Timeout: state stuck %s %s",
					leave ? "in" : "before", target.name()));
			end
		end
	endtask

	task automatic read_cases;
		int    fd;
		int    rows;
		int    n;
		int    a;
		int    b;
		int    c;
		string line;
		fd = $fopen("view_cases.txt", "r");
		if (fd == 0) begin
			abort_run("cannot open view_cases.txt");
		end
		rows = 0;
		while ($fgets(line, fd)) begin
			if (line.len() > 1 && line[0] != "#") begin
				if (rows < `OBJ_COUNT) begin
					n = $sscanf(line, "%d %d %d", a, b, c);
					if (n != 3) begin
						abort_run("bad object line in view_cases.txt");
					end
					obj_x[rows]    = a;
					obj_y[rows]    = b;
					obj_kind[rows] = obj_kind_t'(c);
				end else begin
					n = $sscanf(line, "%d %d", a, b);
					if (n != 2) begin
						abort_run("bad collect line in view_cases.txt");
					end
					coll_idx.push_back(a);
					coll_score.push_back(b);
				end
				rows++;
			end
		end
		$fclose(fd);
		if (rows <= `OBJ_COUNT) begin
			abort_run("view_cases.txt holds no collect cases");
		end
	endtask

	task automatic restore_model;
		int j;
		for (j = 0; j < `OBJ_COUNT; j++) begin
			obj_vis[j] = 1'b1;
		end
		model_score = 0;
	endtask

	task automatic load_map;
		int j;
		for (j = 0; j < `OBJ_COUNT; j++) begin
			map_load         = 1'b1;
			map_index        = obj_index_t'(j);
			map_data.x       = coord_x_t'(obj_x[j]);
			map_data.y       = coord_y_t'(obj_y[j]);
			map_data.kind    = obj_kind[j];
			map_data.visible = 1'b1;
			@(negedge clk);
		end
		map_load = 1'b0;
		restore_model();
	endtask

	task automatic pulse_go;
		go = 1'b1;
		@(negedge clk);
		go = 1'b0;
	endtask

	task automatic collect_object(input int idx);
		collect       = 1'b1;
		collect_index = obj_index_t'(idx);
		@(negedge clk);
		collect     = 1'b0;
		model_score = score_after(idx);
		obj_vis[idx] = 1'b0;
		check(score, model_score, $sformatf("score after collecting object %0d", idx));
	endtask

	task automatic collect_case(input int ci);
		collect_object(coll_idx[ci]);
		check(score, coll_score[ci], $sformatf("score for collect case %0d", ci));
	endtask

	task automatic check_background;
		longint w;
		longint h;
		w = `SCREEN_W;
		h = `SCREEN_H;
		check(bg_count, w * h, "background writes");
		check(bg_sum_x, h * w * (w - 1) / 2, "background column sum");
		check(bg_sum_y, w * h * (h - 1) / 2, "background row sum");
		check(obj_total, 0, "sprite writes during background");
	endtask

	task automatic check_frame;
		int j;
		int expected;
		for (j = 0; j < `OBJ_COUNT; j++) begin
			expected = obj_vis[j] ? SPRITE_WRITES : 0;
			check(obj_hits[j], expected, $sformatf("writes for object %0d", j));
		end
		check(bg_count, 0, "background writes in object frame");
	endtask

	initial begin
		int ci;
		int lvl;
		int j;
		int prev;
		int frames;
		int snapshot;
		resetn        = 1'b0;
		go            = 1'b0;
		map_load      = 1'b0;
		map_index     = '0;
		map_data      = '0;
		collect       = 1'b0;
		collect_index = '0;
		write_total   = 0;
		clear_counts();
		read_cases();
		repeat (4) @(negedge clk);
		resetn = 1'b1;
		@(negedge clk);

		// reset values and one full background pass
		check(write_en, 0, "write_en after reset");
		check(state, IDLE, "state after reset");
		check(level, 0, "level after reset");
		check(score, 0, "score after reset");
		check(time_left, `ROUND_TIME, "time_left after reset");
		load_map();
		pulse_go();
		check(state, CLEAR, "state after go");
		await_state(OBJECTS, 1'b0);
		settle();
		check_background();
		clear_counts();

		// first object frame with every sprite drawn
		await_state(FRAME_END, 1'b0);
		settle();
		check_frame();
		check(obj_total, `OBJ_COUNT * SPRITE_WRITES, "first frame total");
		check(time_left, `ROUND_TIME - 1, "time_left after first frame");

		// collects that stay below the goal
		await_state(FRAME_END, 1'b1);
		ci = 0;
		while (ci < coll_idx.size() && score_after(coll_idx[ci]) < `GOAL_BASE) begin
			collect_case(ci);
			ci++;
		end
		await_state(FRAME_END, 1'b0);
		settle();
		clear_counts();
		await_state(FRAME_END, 1'b1);
		await_state(FRAME_END, 1'b0);
		settle();
		check_frame();

		// the rest reach the goal and level up at frame end
		await_state(FRAME_END, 1'b1);
		while (ci < coll_idx.size()) begin
			collect_case(ci);
			ci++;
		end
		await_state(FRAME_END, 1'b0);
		await_state(FRAME_END, 1'b1);
		check(state, LEVEL_UP, "state after goal met");
		await_state(CLEAR, 1'b0);
		restore_model();
		check(level, 1, "level after level up");
		check(score, 0, "score after level up");
		check(time_left, `ROUND_TIME, "time_left after level up");
		clear_counts();
		await_state(OBJECTS, 1'b0);
		settle();
		check_background();
		clear_counts();
		await_state(FRAME_END, 1'b0);
		settle();
		check_frame();

		// without collects the timer runs out
		prev = `ROUND_TIME - 1;
		check(time_left, prev, "time_left after one frame of level 1");
		frames = 1;
		await_state(FRAME_END, 1'b1);
		while (state != GAME_OVER) begin
			if (frames > `ROUND_TIME) begin
				abort_run("round timer never ran out");
			end
			await_state(FRAME_END, 1'b0);
			await_state(FRAME_END, 1'b1);
			prev = prev - 1;
			check(time_left, prev, "time_left after frame");
			frames++;
		end
		check(time_left, 0, "time_left at game over");
		settle();
		snapshot = write_total;
		repeat (QUIET_CYCLES) @(negedge clk);
		check(write_total, snapshot, "writes after game over");
		check(state, GAME_OVER, "state holds game over");
		pulse_go();
		restore_model();
		check(state, CLEAR, "state after restart");
		check(level, 0, "level after restart");
		check(score, 0, "score after restart");
		check(time_left, `ROUND_TIME, "time_left after restart");

		// clear every level by collecting the whole table
		for (lvl = 0; lvl < `LAST_LEVEL; lvl++) begin
			await_state(OBJECTS, 1'b0);
			check(level, lvl, "level at round start");
			for (j = 0; j < `OBJ_COUNT; j++) begin
				collect_object(j);
			end
			await_state(FRAME_END, 1'b0);
			await_state(FRAME_END, 1'b1);
			if (lvl < `LAST_LEVEL - 1) begin
				check(state, LEVEL_UP, "state after round cleared");
				restore_model();
			end else begin
				check(state, GAME_WIN, "state after last level");
			end
		end

		if (DUT.u_assert.fail_count != 0) begin
			abort_run("a write assertion failed during the run");
		end else begin
			$display("All tests passed");
			$finish;
		end
	end

endmodule

// File: view_cases.txt
# first fifteen lines are objects: x y kind (0 gold, 1 stone, 2 diamond)
# remaining lines are collects: object index, expected score after it
20 30 0
80 30 1
140 30 2
200 30 0
260 30 1
20 100 2
80 100 0
140 100 1
200 100 2
260 100 0
20 170 1
80 170 2
140 170 0
200 170 1
260 170 2
# collects in round 0, the repeated index adds nothing
3 20
3 20
7 25
10 30
0 50
11 100
11 100

// File: view_defs.svh
// game view constants
// screen geometry, sprite shape, palette, object values and round timing
`ifndef VIEW_DEFS_SVH
`define VIEW_DEFS_SVH

`define SCREEN_W      320
`define SCREEN_H      240

`define SPRITE_SIZE   20
`define CORNER_SIZE   2

`define OBJ_COUNT     15

// 12-bit rgb palette
`define COLOR_BG      12'h6a3
`define COLOR_GOLD    12'hfc1
`define COLOR_STONE   12'h888
`define COLOR_DIAMOND 12'h1ef
`define COLOR_CLEAR   12'h000

`define VALUE_GOLD    20
`define VALUE_STONE   5
`define VALUE_DIAMOND 50

`define GOAL_BASE     75
`define GOAL_STEP     75

// object frames per round
`define ROUND_TIME    12
`define LAST_LEVEL    3

`endif

// File: view_pkg.sv
// game view types
// coordinates, colours, round counters, pixel and object records, view states
package view_pkg;

	typedef logic [8:0]  coord_x_t;
	typedef logic [7:0]  coord_y_t;
	typedef logic [11:0] color_t;
	typedef logic [9:0]  score_t;
	typedef logic [2:0]  level_t;
	typedef logic [3:0]  obj_index_t;
	typedef logic [1:0]  obj_kind_t;
	typedef logic [3:0]  time_t;

	localparam obj_kind_t KIND_GOLD    = 2'd0;
	localparam obj_kind_t KIND_STONE   = 2'd1;
	localparam obj_kind_t KIND_DIAMOND = 2'd2;

	typedef struct packed {
		coord_x_t x;
		coord_y_t y;
		color_t   color;
	} pixel_t;

	typedef struct packed {
		coord_x_t  x;
		coord_y_t  y;
		obj_kind_t kind;
		logic      visible;
	} obj_rec_t;

	// base corner plus offset within the area being walked
	typedef struct packed {
		coord_x_t  base_x;
		coord_y_t  base_y;
		coord_x_t  dx;
		coord_y_t  dy;
		obj_kind_t kind;
		logic      visible;
		logic      background;
	} scan_pos_t;

	typedef enum logic [2:0] {
		IDLE,
		CLEAR,
		OBJECTS,
		FRAME_END,
		LEVEL_UP,
		GAME_OVER,
		GAME_WIN
	} view_state_t;

endpackage
